// File: logic/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen = 32;
    localparam int nreg = 32;

    typedef logic [4:0] reg_idx_t;

    // major opcodes, one per instruction format
    localparam logic [16:0] op_add_w   = 17'h00020;
    localparam logic [16:0] op_sub_w   = 17'h00022;
    localparam logic [16:0] op_and     = 17'h00029;
    localparam logic [16:0] op_or      = 17'h0002a;
    localparam logic [9:0]  op_addi_w  = 10'h00a;
    localparam logic [9:0]  op_ld_w    = 10'h0a2;
    localparam logic [9:0]  op_st_w    = 10'h0a6;
    localparam logic [6:0]  op_lu12i_w = 7'h0a;
    localparam logic [5:0]  op_b       = 6'h14;
    localparam logic [5:0]  op_beq     = 6'h16;
    localparam logic [5:0]  op_bne     = 6'h17;

    typedef union packed {
        struct packed {logic [16:0] opcode17; reg_idx_t rk; reg_idx_t rj; reg_idx_t rd;} fmt_3r;
        struct packed {logic [9:0] opcode10; logic [11:0] imm12; reg_idx_t rj; reg_idx_t rd;} fmt_2ri12;
        struct packed {logic [6:0] opcode7; logic [19:0] imm20; reg_idx_t rd;} fmt_1ri20;
        struct packed {logic [5:0] opcode6; logic [15:0] offs16; reg_idx_t rj; reg_idx_t rd;} fmt_2ri16;
        struct packed {logic [5:0] opcode6; logic [25:0] offs26;} fmt_i26; // low half in [25:10]
    } instr_u;

    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_lui} alu_op_e;

    typedef struct packed {logic en; logic [3:0] we; logic [xlen-1:0] addr; logic [xlen-1:0] wdata;} sram_req_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        instr_u          inst;
    } fs_to_ds_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        alu_op_e         alu_op;
        logic [xlen-1:0] src1;
        logic [xlen-1:0] src2;
        reg_idx_t        rd;
        logic            rf_we;
        logic            mem_re;
        logic            mem_we;
        logic [xlen-1:0] st_data;
    } ds_to_es_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] result;
        reg_idx_t        rd;
        logic            rf_we;
        logic            mem_re;
    } es_to_ms_t;

    typedef struct packed {logic [xlen-1:0] pc; logic [xlen-1:0] result; reg_idx_t rd; logic rf_we;} ms_to_ws_t;

    typedef struct packed {logic valid; logic rf_we; reg_idx_t rd; logic [xlen-1:0] value; logic is_load;} fwd_t;

    typedef struct packed {logic taken; logic [xlen-1:0] target;} br_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [3:0]      rf_we;
        reg_idx_t        rf_wnum;
        logic [xlen-1:0] rf_wdata;
    } trace_t;

endpackage

// File: logic/cpu_top.sv
`timescale 1ns/100ps

module cpu_top #(
    parameter logic [cpu_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    output cpu_pkg::sram_req_t        inst_sram,
    input  logic [cpu_pkg::xlen-1:0]  inst_sram_rdata,
    output cpu_pkg::sram_req_t        data_sram,
    input  logic [cpu_pkg::xlen-1:0]  data_sram_rdata,
    output cpu_pkg::trace_t           trace
);
    import cpu_pkg::*;

    logic            ds_allowin, es_allowin, ms_allowin, ws_allowin;
    logic            fs_to_ds_valid, ds_to_es_valid, es_to_ms_valid, ms_to_ws_valid;
    fs_to_ds_t       fs_to_ds;
    ds_to_es_t       ds_to_es;
    es_to_ms_t       es_to_ms;
    ms_to_ws_t       ms_to_ws;
    br_t             br;
    fwd_t            es_fwd, ms_fwd, ws_fwd;
    reg_idx_t        rf_raddr1, rf_raddr2, rf_waddr;
    logic [xlen-1:0] rf_rdata1, rf_rdata2, rf_wdata;
    logic            rf_we;

    if_stage #(.reset_pc(reset_pc)) if_stage_i (
        .clk, .rst_n, .ds_allowin, .br, .inst_sram, .inst_sram_rdata,
        .fs_to_ds_valid, .fs_to_ds
    );

    id_stage id_stage_i (
        .clk, .rst_n, .fs_to_ds_valid, .fs_to_ds, .ds_allowin, .br,
        .es_allowin, .ds_to_es_valid, .ds_to_es,
        .es_fwd, .ms_fwd, .ws_fwd,
        .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2
    );

    regfile regfile_i (
        .clk,
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    ex_stage ex_stage_i (
        .clk, .rst_n, .ds_to_es_valid, .ds_to_es, .es_allowin,
        .ms_allowin, .es_to_ms_valid, .es_to_ms, .es_fwd, .data_sram
    );

    mem_stage mem_stage_i (
        .clk, .rst_n, .es_to_ms_valid, .es_to_ms, .ms_allowin,
        .ws_allowin, .ms_to_ws_valid, .ms_to_ws, .ms_fwd, .data_sram_rdata
    );

    wb_stage wb_stage_i (
        .clk, .rst_n, .ms_to_ws_valid, .ms_to_ws, .ws_allowin, .ws_fwd,
        .rf_we, .rf_waddr, .rf_wdata, .trace
    );

endmodule

// File: logic/ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ds_to_es_valid,
    input  cpu_pkg::ds_to_es_t  ds_to_es,
    output logic                es_allowin,
    input  logic                ms_allowin,
    output logic                es_to_ms_valid,
    output cpu_pkg::es_to_ms_t  es_to_ms,
    output cpu_pkg::fwd_t       es_fwd,
    output cpu_pkg::sram_req_t  data_sram
);
    import cpu_pkg::*;

    logic            es_valid;
    ds_to_es_t       es_r;
    logic [xlen-1:0] alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            es_r <= ds_to_es;
        end
    end

    always_comb begin
        case (es_r.alu_op)
            alu_add: alu_result = es_r.src1 + es_r.src2;
            alu_sub: alu_result = es_r.src1 - es_r.src2;
            alu_and: alu_result = es_r.src1 & es_r.src2;
            alu_or:  alu_result = es_r.src1 | es_r.src2;
            alu_lui: alu_result = es_r.src2;
            default: alu_result = '0;
        endcase
    end

    assign es_allowin     = !es_valid || ms_allowin;
    assign es_to_ms_valid = es_valid;
    assign es_to_ms       = '{pc: es_r.pc, result: alu_result, rd: es_r.rd,
                              rf_we: es_r.rf_we, mem_re: es_r.mem_re};
    assign es_fwd         = '{valid: es_valid, rf_we: es_r.rf_we, rd: es_r.rd,
                              value: alu_result, is_load: es_r.mem_re};

    // issued only on the move into mem, so data lands there
    assign data_sram.en    = es_valid && ms_allowin && (es_r.mem_re || es_r.mem_we);
    assign data_sram.we    = es_r.mem_we ? 4'hf : 4'h0;
    assign data_sram.addr  = alu_result;
    assign data_sram.wdata = es_r.st_data;

endmodule

// File: logic/id_stage.sv
`timescale 1ns/100ps

module id_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      fs_to_ds_valid,
    input  cpu_pkg::fs_to_ds_t        fs_to_ds,
    output logic                      ds_allowin,
    output cpu_pkg::br_t              br,
    input  logic                      es_allowin,
    output logic                      ds_to_es_valid,
    output cpu_pkg::ds_to_es_t        ds_to_es,
    input  cpu_pkg::fwd_t             es_fwd,
    input  cpu_pkg::fwd_t             ms_fwd,
    input  cpu_pkg::fwd_t             ws_fwd,
    output cpu_pkg::reg_idx_t         rf_raddr1,
    output cpu_pkg::reg_idx_t         rf_raddr2,
    input  logic [cpu_pkg::xlen-1:0]  rf_rdata1,
    input  logic [cpu_pkg::xlen-1:0]  rf_rdata2
);
    import cpu_pkg::*;

    logic            ds_valid;
    fs_to_ds_t       ds_r;
    instr_u          inst;
    logic            ds_ready_go;
    logic            is_add, is_sub, is_and, is_or;
    logic            is_addi, is_lu12i, is_ld, is_st;
    logic            is_beq, is_bne, is_b;
    logic            is_3r;
    logic            use_rj, use_r2;
    reg_idx_t        rj, r2;
    logic [xlen-1:0] rj_val, r2_val;
    logic [25:0]     offs26;
    logic            load_use;
    logic            br_cond;

    // pending write in a later stage that id must see
    function automatic logic fwd_hit(fwd_t f, reg_idx_t r);
        return f.valid && f.rf_we && (f.rd == r) && (r != '0);
    endfunction

    function automatic logic [xlen-1:0] fwd_pick(reg_idx_t r, logic [xlen-1:0] rf_val,
                                                 fwd_t es, fwd_t ms, fwd_t ws);
        if (fwd_hit(es, r)) begin
            return es.value; // youngest first
        end else if (fwd_hit(ms, r)) begin
            return ms.value;
        end else if (fwd_hit(ws, r)) begin
            return ws.value;
        end
        return rf_val;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_r <= fs_to_ds;
        end
    end

    assign inst     = ds_r.inst;
    assign is_add   = inst.fmt_3r.opcode17 == op_add_w;
    assign is_sub   = inst.fmt_3r.opcode17 == op_sub_w;
    assign is_and   = inst.fmt_3r.opcode17 == op_and;
    assign is_or    = inst.fmt_3r.opcode17 == op_or;
    assign is_addi  = inst.fmt_2ri12.opcode10 == op_addi_w;
    assign is_ld    = inst.fmt_2ri12.opcode10 == op_ld_w;
    assign is_st    = inst.fmt_2ri12.opcode10 == op_st_w;
    assign is_lu12i = inst.fmt_1ri20.opcode7 == op_lu12i_w;
    assign is_beq   = inst.fmt_2ri16.opcode6 == op_beq;
    assign is_bne   = inst.fmt_2ri16.opcode6 == op_bne;
    assign is_b     = inst.fmt_i26.opcode6 == op_b;
    assign is_3r    = is_add || is_sub || is_and || is_or;

    assign use_rj = is_3r || is_addi || is_ld || is_st || is_beq || is_bne;
    assign use_r2 = is_3r || is_st || is_beq || is_bne;
    assign rj     = inst.fmt_3r.rj;
    assign r2     = (is_st || is_beq || is_bne) ? inst.fmt_2ri16.rd : inst.fmt_3r.rk;

    assign rf_raddr1 = rj;
    assign rf_raddr2 = r2;
    assign rj_val    = fwd_pick(rj, rf_rdata1, es_fwd, ms_fwd, ws_fwd);
    assign r2_val    = fwd_pick(r2, rf_rdata2, es_fwd, ms_fwd, ws_fwd);

    // load in ex has no data yet
    assign load_use = es_fwd.is_load &&
                      ((use_rj && fwd_hit(es_fwd, rj)) || (use_r2 && fwd_hit(es_fwd, r2)));

    assign ds_ready_go    = !load_use;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    assign offs26   = {inst.fmt_i26.offs26[9:0], inst.fmt_i26.offs26[25:10]};
    assign br_cond  = is_b || (is_beq && rj_val == r2_val) || (is_bne && rj_val != r2_val);
    assign br.taken = ds_valid && ds_ready_go && es_allowin && br_cond;
    assign br.target = is_b ? ds_r.pc + {{4{offs26[25]}}, offs26, 2'b00}
                            : ds_r.pc + {{14{inst.fmt_2ri16.offs16[15]}},
                                         inst.fmt_2ri16.offs16, 2'b00};

    always_comb begin
        ds_to_es.pc      = ds_r.pc;
        ds_to_es.rd      = inst.fmt_3r.rd;
        ds_to_es.rf_we   = is_3r || is_addi || is_lu12i || is_ld;
        ds_to_es.mem_re  = is_ld;
        ds_to_es.mem_we  = is_st;
        ds_to_es.st_data = r2_val;
        ds_to_es.src1    = rj_val;
        if (is_3r) begin
            ds_to_es.src2 = r2_val;
        end else if (is_lu12i) begin
            ds_to_es.src2 = {inst.fmt_1ri20.imm20, 12'h000};
        end else begin
            ds_to_es.src2 = {{20{inst.fmt_2ri12.imm12[11]}}, inst.fmt_2ri12.imm12};
        end
        if (is_sub) begin
            ds_to_es.alu_op = alu_sub;
        end else if (is_and) begin
            ds_to_es.alu_op = alu_and;
        end else if (is_or) begin
            ds_to_es.alu_op = alu_or;
        end else if (is_lu12i) begin
            ds_to_es.alu_op = alu_lui;
        end else begin
            ds_to_es.alu_op = alu_add; // also ld/st address
        end
    end

endmodule

// File: logic/if_stage.sv
`timescale 1ns/100ps

module if_stage #(
    parameter logic [cpu_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ds_allowin,
    input  cpu_pkg::br_t              br,
    output cpu_pkg::sram_req_t        inst_sram,
    input  logic [cpu_pkg::xlen-1:0]  inst_sram_rdata,
    output logic                      fs_to_ds_valid,
    output cpu_pkg::fs_to_ds_t        fs_to_ds
);
    import cpu_pkg::*;

    logic            fetch_en_q; // low until one cycle after reset
    logic            fs_valid;
    logic [xlen-1:0] fs_pc;
    logic [xlen-1:0] next_pc;
    logic            fs_allowin;
    logic            req_fire;
    logic            buf_valid;  // rdata already taken into inst_buf
    instr_u          inst_buf;

    assign fs_allowin = !fs_valid || ds_allowin;
    assign req_fire   = fetch_en_q && fs_allowin;
    assign next_pc    = br.taken ? br.target : fs_pc + xlen'(4);

    assign inst_sram.en    = req_fire;
    assign inst_sram.we    = 4'h0;
    assign inst_sram.addr  = next_pc;
    assign inst_sram.wdata = '0;

    assign fs_to_ds_valid = fs_valid && !br.taken; // drop the word behind a taken branch
    assign fs_to_ds.pc    = fs_pc;
    assign fs_to_ds.inst  = buf_valid ? inst_buf : instr_u'(inst_sram_rdata);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_en_q <= 1'b0;
            fs_valid   <= 1'b0;
            fs_pc      <= reset_pc - xlen'(4); // first request lands on reset_pc
            buf_valid  <= 1'b0;
        end else begin
            fetch_en_q <= 1'b1;
            if (fs_allowin) begin
                fs_valid <= req_fire;
            end
            if (req_fire) begin
                fs_pc <= next_pc;
            end
            buf_valid <= fs_valid && !fs_allowin;
        end
    end

    // sram output is only good the cycle after the request
    always_ff @(posedge clk) begin
        if (fs_valid && !fs_allowin && !buf_valid) begin
            inst_buf <= instr_u'(inst_sram_rdata);
        end
    end

endmodule

// File: logic/mem_stage.sv
`timescale 1ns/100ps

module mem_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      es_to_ms_valid,
    input  cpu_pkg::es_to_ms_t        es_to_ms,
    output logic                      ms_allowin,
    input  logic                      ws_allowin,
    output logic                      ms_to_ws_valid,
    output cpu_pkg::ms_to_ws_t        ms_to_ws,
    output cpu_pkg::fwd_t             ms_fwd,
    input  logic [cpu_pkg::xlen-1:0]  data_sram_rdata
);
    import cpu_pkg::*;

    logic            ms_valid;
    es_to_ms_t       ms_r;
    logic [xlen-1:0] ms_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_r <= es_to_ms;
        end
    end

    assign ms_result      = ms_r.mem_re ? data_sram_rdata : ms_r.result; // load word arrives here
    assign ms_allowin     = !ms_valid || ws_allowin;
    assign ms_to_ws_valid = ms_valid;
    assign ms_to_ws       = '{pc: ms_r.pc, result: ms_result, rd: ms_r.rd, rf_we: ms_r.rf_we};
    assign ms_fwd         = '{valid: ms_valid, rf_we: ms_r.rf_we, rd: ms_r.rd,
                              value: ms_result, is_load: 1'b0}; // value already final

endmodule

// File: logic/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic                      clk,
    input  cpu_pkg::reg_idx_t         raddr1,
    input  cpu_pkg::reg_idx_t         raddr2,
    output logic [cpu_pkg::xlen-1:0]  rdata1,
    output logic [cpu_pkg::xlen-1:0]  rdata2,
    input  logic                      we,
    input  cpu_pkg::reg_idx_t         waddr,
    input  logic [cpu_pkg::xlen-1:0]  wdata
);
    import cpu_pkg::*;

    logic [xlen-1:0] regs [nreg];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 entry never written
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: logic/wb_stage.sv
`timescale 1ns/100ps

module wb_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ms_to_ws_valid,
    input  cpu_pkg::ms_to_ws_t        ms_to_ws,
    output logic                      ws_allowin,
    output cpu_pkg::fwd_t             ws_fwd,
    output logic                      rf_we,
    output cpu_pkg::reg_idx_t         rf_waddr,
    output logic [cpu_pkg::xlen-1:0]  rf_wdata,
    output cpu_pkg::trace_t           trace
);
    import cpu_pkg::*;

    logic      ws_valid;
    ms_to_ws_t ws_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_r <= ms_to_ws;
        end
    end

    assign ws_allowin = 1'b1; // retires every cycle
    assign rf_we      = ws_valid && ws_r.rf_we && (ws_r.rd != '0);
    assign rf_waddr   = ws_r.rd;
    assign rf_wdata   = ws_r.result;
    assign ws_fwd     = '{valid: ws_valid, rf_we: rf_we, rd: ws_r.rd,
                          value: ws_r.result, is_load: 1'b0};
    assign trace      = '{valid: ws_valid, pc: ws_r.pc, rf_we: {4{rf_we}},
                          rf_wnum: ws_r.rd, rf_wdata: ws_r.result};

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module cpu_tb -Mdir obj_dir -f src.f
out=$(./obj_dir/Vcpu_tb || true)
echo "$out"
if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// File: src.f
+incdir+verification
logic/cpu_pkg.sv
logic/if_stage.sv
logic/id_stage.sv
logic/regfile.sv
logic/ex_stage.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/cpu_top.sv
verification/cpu_chk.sv
verification/cpu_tb.sv

// File: verification/cpu_chk.sv
`timescale 1ns/100ps

module cpu_chk (
    input logic                clk,
    input logic                rst_n,
    input logic                ds_valid,
    input logic                use_rj,
    input logic                use_r2,
    input cpu_pkg::reg_idx_t   rf_raddr1,
    input cpu_pkg::reg_idx_t   rf_raddr2,
    input cpu_pkg::fwd_t       es_fwd,
    input logic                ds_to_es_valid,
    input logic                br_taken
);

    logic ld_in_ex;
    logic stall;

    // load in ex whose result id still needs
    assign ld_in_ex = es_fwd.valid && es_fwd.is_load && es_fwd.rf_we && (es_fwd.rd != '0);
    assign stall    = ds_valid && ld_in_ex &&
                      ((use_rj && es_fwd.rd == rf_raddr1) || (use_r2 && es_fwd.rd == rf_raddr2));

    stall_blocks_issue: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> !ds_to_es_valid)
        else $error("instruction issued to ex during a load-use stall");

    no_branch_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> !br_taken)
        else $error("branch redirect during a load-use stall");

    // the load leaves ex after one cycle, a bubble follows it
    stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> !stall)
        else $error("load-use stall lasted more than one cycle");

endmodule

bind id_stage cpu_chk chk_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .ds_valid       (ds_valid),
    .use_rj         (use_rj),
    .use_r2         (use_r2),
    .rf_raddr1      (rf_raddr1),
    .rf_raddr2      (rf_raddr2),
    .es_fwd         (es_fwd),
    .ds_to_es_valid (ds_to_es_valid),
    .br_taken       (br.taken)
);

// File: verification/cpu_ref_model.svh
`ifndef cpu_ref_model_svh
`define cpu_ref_model_svh

typedef enum int {i_add, i_sub, i_and, i_or, i_addi, i_lu12i, i_ld, i_st, i_beq, i_bne, i_b} kind_e;
typedef enum int {t_reset, t_alu, t_mem, t_branch, t_r0, t_done} test_e;

localparam int prog_len = 200; // terminator sits at this index
localparam int n_tests  = 6;

logic [15:0] lfsr_state = 16'd12386;
kind_e       prog_kind [prog_len+1];
reg_idx_t    prog_rd   [prog_len+1];
reg_idx_t    prog_rj   [prog_len+1];
reg_idx_t    prog_rk   [prog_len+1];
logic [31:0] prog_imm  [prog_len+1]; // immediate, or branch offset in words
trace_t      exp_trace [$];
test_e       exp_test  [$];
sram_req_t   exp_store [$];

// fibonacci lfsr, taps 16 14 13 11
function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        v          = {v[30:0], fb};
    end
    return v;
endfunction

function automatic logic [31:0] fill_word(logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]} ^ 32'h0bad_f00d;
endfunction

// architectural execution, one entry per retired instruction
task automatic run_model();
    logic [31:0] mregs [32];
    logic [31:0] mdata [64];
    logic [31:0] a, b, val, addr;
    logic        wr;
    int          pc_i;
    int          next;
    kind_e       k;
    reg_idx_t    rd;
    trace_t      tr;
    sram_req_t   st;
    test_e       t;
    for (int j = 0; j < 32; j++)
        mregs[j] = '0;
    for (int j = 0; j < 64; j++)
        mdata[j] = fill_word(32'(j * 4));
    pc_i = 0;
    while (pc_i < prog_len) begin
        k    = prog_kind[pc_i];
        rd   = prog_rd[pc_i];
        a    = mregs[prog_rj[pc_i]];
        b    = (k inside {i_add, i_sub, i_and, i_or}) ? mregs[prog_rk[pc_i]] : mregs[rd];
        addr = a + {{20{prog_imm[pc_i][11]}}, prog_imm[pc_i][11:0]}; // addi and ld/st
        wr   = !(k inside {i_st, i_beq, i_bne, i_b});
        val  = addr;
        next = pc_i + 1;
        case (k)
            i_add:   val = a + b;
            i_sub:   val = a - b;
            i_and:   val = a & b;
            i_or:    val = a | b;
            i_lu12i: val = {prog_imm[pc_i][19:0], 12'h000};
            i_ld:    val = mdata[addr[7:2]];
            i_st: begin
                mdata[addr[7:2]] = b;
                st = '{en: 1'b1, we: 4'hf, addr: addr, wdata: b};
                exp_store.push_back(st);
            end
            i_beq, i_bne, i_b: begin
                if (k == i_b || (k == i_beq && a == b) || (k == i_bne && a != b))
                    next = pc_i + int'(prog_imm[pc_i]);
            end
            default: ;
        endcase
        if (k inside {i_ld, i_st})
            t = t_mem;
        else if (!wr)
            t = t_branch;
        else if (rd == '0)
            t = t_r0;
        else
            t = t_alu;
        tr = '{valid: 1'b1, pc: 32'(pc_i * 4), rf_we: (wr && rd != '0) ? 4'hf : 4'h0,
               rf_wnum: rd, rf_wdata: val};
        exp_trace.push_back(tr);
        exp_test.push_back(t);
        if (wr && rd != '0)
            mregs[rd] = val;
        pc_i = next;
    end
endtask

`endif

// File: verification/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;
    import cpu_pkg::*;

    `include "cpu_ref_model.svh"

    localparam int cycle_limit = 5 * prog_len + 50;

    logic            clk = 1'b0;
    logic            rst_n;
    logic [xlen-1:0] inst_rdata;
    logic [xlen-1:0] data_rdata;
    sram_req_t       inst_sram;
    sram_req_t       data_sram;
    trace_t          trace;
    sram_req_t       inst_req = '0; // request seen in the current cycle
    sram_req_t       data_req = '0;
    logic [31:0]     imem [256];
    logic [31:0]     dmem [64];
    int              checks [n_tests];
    int              errors [n_tests];
    string           test_name [n_tests];
    int              cycle_cnt = 0;
    int              retired = 0;
    int              exp_len = 0;
    logic            retired_any = 1'b0;
    logic            term_seen = 1'b0;
    logic            done = 1'b0;

    cpu_top #(.reset_pc(32'h0)) dut_i (
        .clk, .rst_n, .inst_sram, .inst_sram_rdata(inst_rdata),
        .data_sram, .data_sram_rdata(data_rdata), .trace
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] encode(int idx);
        logic [31:0] imm;
        imm = prog_imm[idx];
        case (prog_kind[idx])
            i_add:   return {op_add_w, prog_rk[idx], prog_rj[idx], prog_rd[idx]};
            i_sub:   return {op_sub_w, prog_rk[idx], prog_rj[idx], prog_rd[idx]};
            i_and:   return {op_and, prog_rk[idx], prog_rj[idx], prog_rd[idx]};
            i_or:    return {op_or, prog_rk[idx], prog_rj[idx], prog_rd[idx]};
            i_addi:  return {op_addi_w, imm[11:0], prog_rj[idx], prog_rd[idx]};
            i_ld:    return {op_ld_w, imm[11:0], prog_rj[idx], prog_rd[idx]};
            i_st:    return {op_st_w, imm[11:0], prog_rj[idx], prog_rd[idx]};
            i_lu12i: return {op_lu12i_w, imm[19:0], prog_rd[idx]};
            i_beq:   return {op_beq, imm[15:0], prog_rj[idx], prog_rd[idx]};
            i_bne:   return {op_bne, imm[15:0], prog_rj[idx], prog_rd[idx]};
            default: return {op_b, imm[15:0], imm[25:16]}; // offs26 split high/low
        endcase
    endfunction

    task automatic gen_program();
        logic [3:0] pick;
        int         k;
        for (int i = 0; i <= prog_len; i++) begin
            prog_rd[i]  = reg_idx_t'(rand_bits(3));
            prog_rj[i]  = reg_idx_t'(rand_bits(3));
            prog_rk[i]  = reg_idx_t'(rand_bits(3));
            prog_imm[i] = rand_bits(20);
            pick        = 4'(rand_bits(4));
            if (i < 7) begin
                prog_kind[i] = i_addi; // seeds r1..r7
                prog_rd[i]   = reg_idx_t'(i + 1);
                prog_rj[i]   = '0;
            end else if (i == prog_len) begin
                prog_kind[i] = i_b;
                prog_imm[i]  = '0; // spins on itself
            end else begin
                case (pick)
                    4'd0, 4'd1:         prog_kind[i] = i_add;
                    4'd2:               prog_kind[i] = i_sub;
                    4'd3:               prog_kind[i] = i_and;
                    4'd4:               prog_kind[i] = i_or;
                    4'd5, 4'd6:         prog_kind[i] = i_addi;
                    4'd7:               prog_kind[i] = i_lu12i;
                    4'd8, 4'd9, 4'd15:  prog_kind[i] = i_ld;
                    4'd10, 4'd11:       prog_kind[i] = i_st;
                    4'd12:              prog_kind[i] = i_beq;
                    4'd13:              prog_kind[i] = i_bne;
                    default:            prog_kind[i] = i_b;
                endcase
                if (prog_kind[i] inside {i_ld, i_st}) begin
                    prog_rj[i]  = '0; // 64-word window from address 0
                    prog_imm[i] = {24'h0, prog_imm[i][5:0], 2'b00};
                end else if (prog_kind[i] inside {i_beq, i_bne, i_b}) begin
                    k = int'(prog_imm[i][1:0]) + 1;
                    if (i + k > prog_len)
                        k = prog_len - i;
                    prog_imm[i] = 32'(k);
                end
            end
        end
    endtask

    task automatic compare_trace(trace_t got);
        trace_t want;
        test_e  t;
        if (exp_trace.size() == 0) begin
            checks[t_branch]++;
            if (got.pc == 32'(prog_len * 4)) begin
                term_seen = 1'b1;
            end else begin
                errors[t_branch]++;
                $display("FAILED %0t: pc %h retired after the program end", $time, got.pc);
            end
        end else begin
            want = exp_trace.pop_front();
            t    = exp_test.pop_front();
            checks[t]++;
            if (got.pc != want.pc || got.rf_we != want.rf_we ||
                (want.rf_we != 4'h0 && (got.rf_wnum != want.rf_wnum ||
                                        got.rf_wdata != want.rf_wdata))) begin
                errors[t]++;
                $display("FAILED %0t: retired pc %h we %h r%0d=%h, expected pc %h we %h r%0d=%h",
                         $time, got.pc, got.rf_we, got.rf_wnum, got.rf_wdata,
                         want.pc, want.rf_we, want.rf_wnum, want.rf_wdata);
            end
        end
    endtask

    task automatic compare_store(sram_req_t got);
        sram_req_t want;
        checks[t_mem]++;
        if (exp_store.size() == 0) begin
            errors[t_mem]++;
            $display("store to %h at %0t, but the program has no store left", got.addr, $time);
        end else begin
            want = exp_store.pop_front();
            if (got != want) begin
                errors[t_mem]++;
                $display("FAILED %0t: store addr %h data %h we %h, expected addr %h data %h we %h",
                         $time, got.addr, got.wdata, got.we, want.addr, want.wdata, want.we);
            end
        end
    endtask

    // sram models, one cycle read latency
    always @(posedge clk) begin
        #1;
        if (inst_req.en)
            inst_rdata = imem[inst_req.addr[9:2]];
        if (data_req.en) begin
            if (data_req.we != 4'h0)
                dmem[data_req.addr[7:2]] = data_req.wdata;
            else
                data_rdata = dmem[data_req.addr[7:2]];
        end
    end

    always @(negedge clk) begin
        inst_req = inst_sram;
        data_req = data_sram;
        if (!rst_n || !retired_any) begin
            checks[t_reset]++;
            if ((!rst_n && (trace.valid || inst_sram.en)) || data_sram.en) begin
                errors[t_reset]++;
                $display("FAILED %0t: early activity, trace valid %b inst en %b data en %b",
                         $time, trace.valid, inst_sram.en, data_sram.en);
            end
        end
        if (rst_n && !done) begin
            if (trace.valid) begin
                retired_any = 1'b1;
                retired++;
                compare_trace(trace);
            end
            if (data_sram.en && data_sram.we != 4'h0)
                compare_store(data_sram);
            if (term_seen) begin
                checks[t_done]++;
                if (retired != exp_len + 1) begin
                    errors[t_done]++;
                    $display("FAILED %0t: %0d retires, expected %0d", $time, retired, exp_len + 1);
                end
                checks[t_mem]++;
                if (exp_store.size() != 0) begin
                    errors[t_mem]++;
                    $display("%0d expected stores never reached the data SRAM", exp_store.size());
                end
                done = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit && !done) begin
            $display("timeout: %0d cycles ran and only %0d instructions retired",
                     cycle_limit, retired);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        int total_checks;
        int total_errors;
        rst_n      = 1'b0;
        inst_rdata = '0;
        data_rdata = '0;
        test_name  = '{"reset", "alu", "load/store", "branch", "r0 writes", "completion"};
        gen_program();
        for (int j = 0; j < 256; j++)
            imem[j] = fill_word(32'(j * 4));
        for (int j = 0; j <= prog_len; j++)
            imem[j] = encode(j);
        for (int j = 0; j < 64; j++)
            dmem[j] = fill_word(32'(j * 4));
        run_model();
        exp_len = exp_trace.size();
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        wait (done);
        total_checks = 0;
        total_errors = 0;
        for (int t = 0; t < n_tests; t++) begin
            $display("%s: %0d checks, %0d errors", test_name[t], checks[t], errors[t]);
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("all tests: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
